/* src/icacheGeomPkg.sv */
package icacheGeomPkg;

    // Cache organisation.
    localparam int numWays      = 4;
    localparam int numSets      = 128;
    localparam int wordsPerLine = 8;

    // Upper part of the physical address.
    typedef logic [19:0] tagT;

    // Set number taken from the page offset.
    typedef logic [6:0] indexT;

    // Byte position inside a 32-byte line.
    typedef logic [4:0] offsetT;

    // Index followed by offset.
    typedef logic [$bits(indexT)+$bits(offsetT)-1:0] pgOffsetT;

    typedef logic [$bits(tagT)+$bits(pgOffsetT)-1:0] addrT;

    typedef logic [31:0] wordT;

    // Word 0 sits in the low bits.
    typedef logic [wordsPerLine*$bits(wordT)-1:0] lineT;

    typedef logic [1:0] wayT;

endpackage

/* src/icacheCtrlPkg.sv */
package icacheCtrlPkg;

    // Age of a way within its set, 0 is the most recently used.
    typedef logic [1:0] ageT;

    // Ages stop counting here.
    localparam ageT ageMax = 2'd3;

    // Fetch sequence.
    // A hit goes IDLE, LOOKUP, IDLE.
    // A miss goes IDLE, LOOKUP, SELECT, REFILL, IDLE.
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        SELECT,
        REFILL
    } fetchStateT;

endpackage

/* src/wayInfoIf.sv */
`timescale 1ns/100ps

interface wayInfoIf;

    logic                              readEn;
    logic                              writeEn;
    icacheGeomPkg::indexT              index;

    // Set contents, valid one cycle after readEn.
    icacheGeomPkg::tagT                tags [icacheGeomPkg::numWays];
    icacheCtrlPkg::ageT                ages [icacheGeomPkg::numWays];
    logic [icacheGeomPkg::numWays-1:0] valid;

    // Replacement contents for the whole set.
    icacheGeomPkg::tagT                newTags [icacheGeomPkg::numWays];
    icacheCtrlPkg::ageT                newAges [icacheGeomPkg::numWays];
    logic [icacheGeomPkg::numWays-1:0] newValid;

    modport store (
        input  readEn, writeEn, index,
        input  newTags, newAges, newValid,
        output tags, ages, valid
    );

    modport user (
        output readEn, writeEn, index,
        output newTags, newAges, newValid,
        input  tags, ages, valid
    );

endinterface

/* src/ctrlStore.sv */
`timescale 1ns/100ps

module ctrlStore (
    input  logic     clk,
    input  logic     resetn,
    wayInfoIf.store  ways
);

    icacheGeomPkg::tagT tagMem [icacheGeomPkg::numSets][icacheGeomPkg::numWays];
    icacheCtrlPkg::ageT ageMem [icacheGeomPkg::numSets][icacheGeomPkg::numWays];

    logic [icacheGeomPkg::numWays-1:0] validMem [icacheGeomPkg::numSets];

    // Tags and ages of a set are replaced together.
    always_ff @(posedge clk) begin
        if (ways.writeEn) begin
            tagMem[ways.index] <= ways.newTags;
            ageMem[ways.index] <= ways.newAges;
        end
    end

    // Cold cache after reset.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < icacheGeomPkg::numSets; s++) begin
                validMem[s] <= '0;
            end
        end else if (ways.writeEn) begin
            validMem[ways.index] <= ways.newValid;
        end
    end

    // One cycle read latency.
    always_ff @(posedge clk) begin
        if (ways.readEn) begin
            ways.tags  <= tagMem[ways.index];
            ways.ages  <= ageMem[ways.index];
            ways.valid <= validMem[ways.index];
        end
    end

endmodule

/* src/dataStore.sv */
`timescale 1ns/100ps

module dataStore (
    input  logic                 clk,
    input  logic                 readEn,
    input  logic                 writeEn,
    input  icacheGeomPkg::indexT index,
    input  icacheGeomPkg::wayT   writeWay,
    input  icacheGeomPkg::lineT  writeLine,
    output icacheGeomPkg::lineT  readLines [icacheGeomPkg::numWays]
);

    icacheGeomPkg::lineT lineMem [icacheGeomPkg::numSets][icacheGeomPkg::numWays];

    // A refill touches a single way, the others keep their lines.
    always_ff @(posedge clk) begin
        if (writeEn) begin
            lineMem[index][writeWay] <= writeLine;
        end
    end

    // All ways come out together so the hit way can be picked late.
    always_ff @(posedge clk) begin
        if (readEn) begin
            for (int w = 0; w < icacheGeomPkg::numWays; w++) begin
                readLines[w] <= lineMem[index][w];
            end
        end
    end

endmodule

/* src/replacePolicy.sv */
`timescale 1ns/100ps

module replacePolicy (
    input  icacheGeomPkg::tagT         tag,
    input  icacheGeomPkg::tagT         tags [icacheGeomPkg::numWays],
    input  icacheCtrlPkg::ageT         ages [icacheGeomPkg::numWays],
    input  logic [icacheGeomPkg::numWays-1:0] valid,
    output logic                       hit,
    output icacheGeomPkg::wayT         hitWay,
    output icacheGeomPkg::wayT         victimWay,
    output icacheCtrlPkg::ageT         newAges [icacheGeomPkg::numWays]
);

    logic [icacheGeomPkg::numWays-1:0] hitVec;
    icacheGeomPkg::wayT                oldestWay;
    icacheGeomPkg::wayT                touchedWay;
    logic                              touchedValid;
    icacheCtrlPkg::ageT                touchedAge;

    always_comb begin
        for (int w = 0; w < icacheGeomPkg::numWays; w++) begin
            hitVec[w] = valid[w] && (tags[w] == tag);
        end
    end

    assign hit = |hitVec;

    always_comb begin
        hitWay = '0;
        for (int w = icacheGeomPkg::numWays - 1; w >= 0; w--) begin
            if (hitVec[w]) begin
                hitWay = icacheGeomPkg::wayT'(w);
            end
        end
    end

    // Strict compare keeps the lowest way on equal ages.
    always_comb begin
        oldestWay = '0;
        for (int w = 1; w < icacheGeomPkg::numWays; w++) begin
            if (ages[w] > ages[oldestWay]) begin
                oldestWay = icacheGeomPkg::wayT'(w);
            end
        end
    end

    // An empty way is always preferred over the oldest one.
    always_comb begin
        victimWay = oldestWay;
        for (int w = icacheGeomPkg::numWays - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victimWay = icacheGeomPkg::wayT'(w);
            end
        end
    end

    assign touchedWay   = hit ? hitWay : victimWay;
    assign touchedValid = valid[touchedWay];
    assign touchedAge   = ages[touchedWay];

    always_comb begin
        for (int w = 0; w < icacheGeomPkg::numWays; w++) begin
            if (icacheGeomPkg::wayT'(w) == touchedWay) begin
                newAges[w] = '0;
            end else if (!touchedValid) begin
                // Filling an empty way ages every live line.
                if (valid[w] && (ages[w] != icacheCtrlPkg::ageMax)) begin
                    newAges[w] = ages[w] + 1'b1;
                end else begin
                    newAges[w] = ages[w];
                end
            end else if (ages[w] < touchedAge) begin
                newAges[w] = ages[w] + 1'b1;
            end else begin
                newAges[w] = ages[w];
            end
        end
    end

endmodule

/* src/icacheControl.sv */
`timescale 1ns/100ps

module icacheControl (
    input  logic                    clk,
    input  logic                    resetn,
    input  icacheGeomPkg::pgOffsetT pgOffsetIn,
    input  logic                    pgOffsetValid,
    input  icacheGeomPkg::tagT      tagIn,
    input  logic                    tagValid,
    input  icacheGeomPkg::lineT     readLines [icacheGeomPkg::numWays],
    input  icacheGeomPkg::lineT     refillLine,
    input  logic                    dataRequestedReady,
    input  logic                    data2ICacheBlkReady,
    wayInfoIf.user                  ways,
    output logic                    dataReadEn,
    output logic                    dataWriteEn,
    output icacheGeomPkg::indexT    dataIndex,
    output icacheGeomPkg::wayT      dataWriteWay,
    output icacheGeomPkg::wordT     dataOut,
    output logic                    dataOutReady,
    output logic                    busy,
    output icacheGeomPkg::addrT     addr2Cache2,
    output logic                    addr2Cache2Valid
);

    icacheCtrlPkg::fetchStateT state;

    icacheGeomPkg::tagT       fetchTag;
    icacheGeomPkg::pgOffsetT  fetchPgOffset;
    icacheGeomPkg::indexT     fetchIndex;
    icacheGeomPkg::offsetT    fetchOffset;
    icacheGeomPkg::indexT     lineIndex;

    logic                     accept;
    logic                     refillDone;
    logic                     hit;
    icacheGeomPkg::wayT       hitWay;
    icacheGeomPkg::wayT       victimWay;
    icacheCtrlPkg::ageT       policyAges [icacheGeomPkg::numWays];

    // Way information carried from LOOKUP into SELECT.
    icacheGeomPkg::wayT       savedVictim;
    icacheGeomPkg::tagT       savedTags [icacheGeomPkg::numWays];
    icacheCtrlPkg::ageT       savedAges [icacheGeomPkg::numWays];
    logic [icacheGeomPkg::numWays-1:0] savedValid;

    icacheGeomPkg::lineT      outLine;
    logic [$clog2(icacheGeomPkg::wordsPerLine)-1:0] wordSel;

    assign accept = (state == icacheCtrlPkg::IDLE) && pgOffsetValid && tagValid;
    assign refillDone = (state == icacheCtrlPkg::REFILL)
                        && dataRequestedReady && data2ICacheBlkReady;

    assign {fetchIndex, fetchOffset} = fetchPgOffset;
    assign wordSel = fetchOffset[4:2];

    // Reads only start in IDLE, so the incoming index never meets a write.
    assign lineIndex = accept ? pgOffsetIn[11:5] : fetchIndex;

    replacePolicy policy (
        .tag       (fetchTag),
        .tags      (ways.tags),
        .ages      (ways.ages),
        .valid     (ways.valid),
        .hit       (hit),
        .hitWay    (hitWay),
        .victimWay (victimWay),
        .newAges   (policyAges)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= icacheCtrlPkg::IDLE;
        end else begin
            case (state)
                icacheCtrlPkg::IDLE: begin
                    if (accept) begin
                        state <= icacheCtrlPkg::LOOKUP;
                    end
                end
                icacheCtrlPkg::LOOKUP: begin
                    state <= hit ? icacheCtrlPkg::IDLE : icacheCtrlPkg::SELECT;
                end
                icacheCtrlPkg::SELECT: begin
                    state <= icacheCtrlPkg::REFILL;
                end
                default: begin
                    if (refillDone) begin
                        state <= icacheCtrlPkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetchTag      <= tagIn;
            fetchPgOffset <= pgOffsetIn;
        end
        if (state == icacheCtrlPkg::LOOKUP) begin
            savedVictim <= victimWay;
            savedTags   <= ways.tags;
            savedAges   <= policyAges;
            savedValid  <= ways.valid;
        end
    end

    assign ways.readEn  = accept;
    assign ways.writeEn = ((state == icacheCtrlPkg::LOOKUP) && hit)
                          || (state == icacheCtrlPkg::SELECT);
    assign ways.index   = lineIndex;

    // A hit only rewrites ages, a miss claims the victim way.
    always_comb begin
        for (int w = 0; w < icacheGeomPkg::numWays; w++) begin
            if (state == icacheCtrlPkg::SELECT) begin
                ways.newTags[w]  = (icacheGeomPkg::wayT'(w) == savedVictim) ? fetchTag
                                                                             : savedTags[w];
                ways.newAges[w]  = savedAges[w];
                ways.newValid[w] = savedValid[w] || (icacheGeomPkg::wayT'(w) == savedVictim);
            end else begin
                ways.newTags[w]  = ways.tags[w];
                ways.newAges[w]  = policyAges[w];
                ways.newValid[w] = ways.valid[w];
            end
        end
    end

    assign dataReadEn   = accept;
    assign dataWriteEn  = refillDone;
    assign dataIndex    = lineIndex;
    assign dataWriteWay = savedVictim;

    assign outLine = (state == icacheCtrlPkg::REFILL) ? refillLine : readLines[hitWay];
    assign dataOut = outLine[wordSel*$bits(icacheGeomPkg::wordT) +: $bits(icacheGeomPkg::wordT)];

    assign dataOutReady     = ((state == icacheCtrlPkg::LOOKUP) && hit) || refillDone;
    assign busy             = (state != icacheCtrlPkg::IDLE);
    assign addr2Cache2      = {fetchTag, fetchIndex, icacheGeomPkg::offsetT'(0)};
    assign addr2Cache2Valid = (state == icacheCtrlPkg::REFILL);

endmodule

/* src/icacheTop.sv */
`timescale 1ns/100ps

module icacheTop (
    input  logic                    clk,
    input  logic                    resetn,

    input  icacheGeomPkg::pgOffsetT pgOffsetIn,
    input  logic                    pgOffsetValid,
    input  icacheGeomPkg::tagT      tagIn,
    input  logic                    tagValid,
    output icacheGeomPkg::wordT     dataOut,
    output logic                    dataOutReady,
    output logic                    busy,

    output icacheGeomPkg::addrT     addr2Cache2,
    output logic                    addr2Cache2Valid,
    input  icacheGeomPkg::lineT     refillLine,
    input  logic                    dataRequestedReady,
    input  logic                    data2ICacheBlkReady
);

    wayInfoIf ways ();

    logic                 dataReadEn;
    logic                 dataWriteEn;
    icacheGeomPkg::indexT dataIndex;
    icacheGeomPkg::wayT   dataWriteWay;
    icacheGeomPkg::lineT  readLines [icacheGeomPkg::numWays];

    ctrlStore ctrl (
        .clk    (clk),
        .resetn (resetn),
        .ways   (ways.store)
    );

    // Refill data goes straight into the victim way.
    dataStore data (
        .clk       (clk),
        .readEn    (dataReadEn),
        .writeEn   (dataWriteEn),
        .index     (dataIndex),
        .writeWay  (dataWriteWay),
        .writeLine (refillLine),
        .readLines (readLines)
    );

    icacheControl control (
        .clk                 (clk),
        .resetn              (resetn),
        .pgOffsetIn          (pgOffsetIn),
        .pgOffsetValid       (pgOffsetValid),
        .tagIn               (tagIn),
        .tagValid            (tagValid),
        .readLines           (readLines),
        .refillLine          (refillLine),
        .dataRequestedReady  (dataRequestedReady),
        .data2ICacheBlkReady (data2ICacheBlkReady),
        .ways                (ways.user),
        .dataReadEn          (dataReadEn),
        .dataWriteEn         (dataWriteEn),
        .dataIndex           (dataIndex),
        .dataWriteWay        (dataWriteWay),
        .dataOut             (dataOut),
        .dataOutReady        (dataOutReady),
        .busy                (busy),
        .addr2Cache2         (addr2Cache2),
        .addr2Cache2Valid    (addr2Cache2Valid)
    );

endmodule

/* verification/icache_assertions.sv */
`timescale 1ns/100ps

module icacheAssertions (
    input logic                clk,
    input logic                resetn,
    input logic                busy,
    input logic                dataOutReady,
    input icacheGeomPkg::addrT addr2Cache2,
    input logic                addr2Cache2Valid,
    input logic                dataRequestedReady,
    input logic                data2ICacheBlkReady
);

    // Number of property failures seen so far.
    int failCount = 0;

    reqNeedsBusy: assert property (@(posedge clk) disable iff (!resetn)
        addr2Cache2Valid |-> busy)
        else begin
            failCount++;
            $error("refill request raised while the cache is idle");
        end

    // Line requests are always aligned.
    reqAligned: assert property (@(posedge clk) disable iff (!resetn)
        addr2Cache2Valid |-> (addr2Cache2[4:0] == '0))
        else begin
            failCount++;
            $error("refill address not line aligned");
        end

    reqHeld: assert property (@(posedge clk) disable iff (!resetn)
        (addr2Cache2Valid && !(dataRequestedReady && data2ICacheBlkReady))
        |=> addr2Cache2Valid)
        else begin
            failCount++;
            $error("refill request dropped before completion");
        end

    wordSingle: assert property (@(posedge clk) disable iff (!resetn)
        dataOutReady |=> !dataOutReady)
        else begin
            failCount++;
            $error("dataOutReady high in two consecutive cycles");
        end

endmodule

/* verification/icacheTb.sv */
`timescale 1ns/100ps

module icacheTb;

    localparam int clkPeriod      = 100;
    localparam int drvDelay       = 10;
    localparam int maxRefillDelay = 6;
    localparam int numFetches     = 86;
    localparam int cycleLimit     = numFetches * (maxRefillDelay + 4) + 100;

    typedef struct packed {
        icacheGeomPkg::tagT      tag;
        icacheGeomPkg::pgOffsetT pgOff;
        icacheGeomPkg::wordT     word;
        logic                    miss;
        icacheGeomPkg::addrT     reqAddr;
        int                      latency;
        logic                    protoOk;
    } fetchObsT;

    logic                    clk;
    logic                    resetn;
    icacheGeomPkg::pgOffsetT pgOffsetIn;
    logic                    pgOffsetValid;
    icacheGeomPkg::tagT      tagIn;
    logic                    tagValid;
    icacheGeomPkg::wordT     dataOut;
    logic                    dataOutReady;
    logic                    busy;
    icacheGeomPkg::addrT     addr2Cache2;
    logic                    addr2Cache2Valid;
    icacheGeomPkg::lineT     refillLine;
    logic                    dataRequestedReady;
    logic                    data2ICacheBlkReady;

    fetchObsT    obsQ [$];
    int unsigned lcgState = 40224;
    int          errors = 0;
    int          checks = 0;
    int          fetchCount = 0;
    int          testCount = 0;
    int          testErrStart = 0;
    int          testFetchStart = 0;
    int          cycleCount = 0;

    // Cache state as predicted from the replacement rules.
    icacheGeomPkg::tagT modelTag   [icacheGeomPkg::numSets][icacheGeomPkg::numWays];
    int                 modelAge   [icacheGeomPkg::numSets][icacheGeomPkg::numWays];
    bit                 modelValid [icacheGeomPkg::numSets][icacheGeomPkg::numWays];

    icacheTop DUT (.*);

    bind icacheTop icacheAssertions checker0 (.*);

    initial begin : clockGen
        clk = 0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    function automatic int randDelay();
        return nextRand() % (maxRefillDelay + 1);
    endfunction

    // Compare failures plus failures of the bound properties.
    function automatic int totalErrors();
        return errors + DUT.checker0.failCount;
    endfunction

    function automatic icacheGeomPkg::pgOffsetT makePgOffset(input int index, input int word);
        return icacheGeomPkg::pgOffsetT'((index << 5) | (word << 2));
    endfunction

    // Memory contents, an odd multiplier spreads every address bit.
    function automatic icacheGeomPkg::wordT memWord(input icacheGeomPkg::addrT a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_3C3C;
    endfunction

    function automatic icacheGeomPkg::lineT makeLine(input icacheGeomPkg::addrT lineAddr);
        icacheGeomPkg::lineT line;
        for (int w = 0; w < icacheGeomPkg::wordsPerLine; w++) begin
            line[w*32 +: 32] = memWord(lineAddr + icacheGeomPkg::addrT'(w * 4));
        end
        return line;
    endfunction

    // Returns the expected hit and moves the model to its next state.
    function automatic logic modelAccess(input icacheGeomPkg::tagT t, input int idx);
        int  touched;
        int  oldAge;
        bit  wasValid;
        logic isHit;
        touched = -1;
        for (int w = 0; w < icacheGeomPkg::numWays; w++) begin
            if (modelValid[idx][w] && modelTag[idx][w] == t) begin
                touched = w;
            end
        end
        isHit = (touched >= 0);
        if (!isHit) begin
            for (int w = icacheGeomPkg::numWays - 1; w >= 0; w--) begin
                if (!modelValid[idx][w]) begin
                    touched = w;
                end
            end
        end
        if (touched < 0) begin
            touched = 0;
            for (int w = 1; w < icacheGeomPkg::numWays; w++) begin
                if (modelAge[idx][w] > modelAge[idx][touched]) begin
                    touched = w;
                end
            end
        end
        wasValid = modelValid[idx][touched];
        oldAge = modelAge[idx][touched];
        for (int w = 0; w < icacheGeomPkg::numWays; w++) begin
            if (w != touched) begin
                if (!wasValid && modelValid[idx][w] && modelAge[idx][w] < 3) begin
                    modelAge[idx][w]++;
                end else if (wasValid && modelAge[idx][w] < oldAge) begin
                    modelAge[idx][w]++;
                end
            end
        end
        modelAge[idx][touched] = 0;
        modelValid[idx][touched] = 1;
        modelTag[idx][touched] = t;
        return isHit;
    endfunction

    // Starts and ends just after a rising edge, serving the refill side on a miss.
    task automatic runFetch(input icacheGeomPkg::tagT t, input icacheGeomPkg::pgOffsetT p,
                            input int delay);
        fetchObsT o;
        int holdLeft;
        logic gotWord;
        o = '0;
        o.tag = t;
        o.pgOff = p;
        o.protoOk = 1;
        holdLeft = delay;
        gotWord = 0;
        while (busy) begin
            @(posedge clk);
            #drvDelay;
        end
        tagIn = t;
        pgOffsetIn = p;
        tagValid = 1;
        pgOffsetValid = 1;
        @(posedge clk);
        #drvDelay;
        tagValid = 0;
        pgOffsetValid = 0;
        while (!gotWord) begin
            @(negedge clk);
            o.latency++;
            if (dataOutReady) begin
                o.word = dataOut;
                gotWord = 1;
                if (o.miss && !(dataRequestedReady && data2ICacheBlkReady)) begin
                    o.protoOk = 0;
                end
            end else begin
                if (o.miss && !(busy && addr2Cache2Valid)) begin
                    o.protoOk = 0;
                end
                if (addr2Cache2Valid && !o.miss) begin
                    o.miss = 1;
                    o.reqAddr = addr2Cache2;
                end
                @(posedge clk);
                #drvDelay;
                if (o.miss) begin
                    refillLine = makeLine(o.reqAddr);
                    if (holdLeft == 0) begin
                        dataRequestedReady = 1;
                        data2ICacheBlkReady = 1;
                    end else begin
                        // Only one ready at a time while holding back.
                        dataRequestedReady = (holdLeft % 2 == 1);
                        data2ICacheBlkReady = (holdLeft % 2 == 0);
                        holdLeft--;
                    end
                end
            end
        end
        @(posedge clk);
        #drvDelay;
        dataRequestedReady = 0;
        data2ICacheBlkReady = 0;
        fetchCount++;
        obsQ.push_back(o);
    endtask

    task automatic endTest(input string name);
        int testErrors;
        wait (obsQ.size() == 0);
        testCount++;
        testErrors = totalErrors() - testErrStart;
        if (testErrors == 0) begin
            $display("test %0d %s: %0d fetches, passed", testCount, name,
                     fetchCount - testFetchStart);
        end else begin
            $display("test %0d %s: %0d fetches, %0d errors", testCount, name,
                     fetchCount - testFetchStart, testErrors);
        end
        testErrStart = totalErrors();
        testFetchStart = fetchCount;
    endtask

    initial begin : compare
        fetchObsT            o;
        logic                expHit;
        icacheGeomPkg::wordT expWord;
        icacheGeomPkg::addrT expAddr;
        forever begin
            wait (obsQ.size() > 0);
            o = obsQ[0];
            expHit = modelAccess(o.tag, o.pgOff[11:5]);
            expWord = memWord({o.tag, o.pgOff[11:2], 2'b00});
            expAddr = {o.tag, o.pgOff[11:5], 5'b0};
            checks += 3;
            assert (o.word == expWord) else begin
                errors++;
                $display("error at %0t: dataOut = %h, expected %h", $time, o.word, expWord);
            end
            assert (o.miss == !expHit) else begin
                errors++;
                $display("error at %0t: addr2Cache2Valid raised = %0b, expected %0b",
                         $time, o.miss, !expHit);
            end
            assert (o.protoOk) else begin
                errors++;
                $display("refill handshake broken for tag %h: request dropped or early word",
                         o.tag);
            end
            if (expHit) begin
                checks++;
                assert (o.latency == 1) else begin
                    errors++;
                    $display("hit on tag %h returned after %0d cycles instead of 1",
                             o.tag, o.latency);
                end
            end else if (o.miss) begin
                checks++;
                assert (o.reqAddr == expAddr) else begin
                    errors++;
                    $display("error at %0t: addr2Cache2 = %h, expected %h",
                             $time, o.reqAddr, expAddr);
                end
            end
            obsQ.delete(0);
        end
    end

    initial begin : watchdog
        while (cycleCount <= cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, a fetch never completed", cycleCount);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        icacheGeomPkg::tagT t;
        int setSel;
        resetn = 0;
        pgOffsetIn = '0;
        pgOffsetValid = 0;
        tagIn = '0;
        tagValid = 0;
        refillLine = '0;
        dataRequestedReady = 0;
        data2ICacheBlkReady = 0;
        repeat (3) @(posedge clk);
        #drvDelay;
        resetn = 1;

        for (int i = 0; i < 4; i++) begin
            runFetch(20'hA0001 + i, makePgOffset(5, 2 * i + 1), randDelay());
        end
        endTest("cold misses");

        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 4; i++) begin
                runFetch(20'hA0001 + i, makePgOffset(5, (i + 3 * r + 5) % 8), 0);
            end
        end
        endTest("hits");

        // The fifth tag pushes out the first one.
        runFetch(20'hA0005, makePgOffset(5, 0), randDelay());
        for (int i = 1; i < 4; i++) begin
            runFetch(20'hA0001 + i, makePgOffset(5, 7 - i), 0);
        end
        runFetch(20'hA0001, makePgOffset(5, 2), randDelay());
        endTest("eviction");

        for (int i = 0; i < 4; i++) begin
            runFetch(20'hB0001 + i, makePgOffset(9, i), randDelay());
        end
        runFetch(20'hB0001, makePgOffset(9, 6), 0);
        runFetch(20'hB0005, makePgOffset(9, 1), randDelay());
        runFetch(20'hB0001, makePgOffset(9, 3), 0);
        runFetch(20'hB0002, makePgOffset(9, 4), randDelay());
        endTest("age update");

        runFetch(20'h00005, makePgOffset(20, 4), maxRefillDelay);
        endTest("back-pressure");

        for (int n = 0; n < 60; n++) begin
            setSel = nextRand() % 3;
            t = 20'hC0000 + nextRand() % 6;
            runFetch(t, makePgOffset(40 + setSel, nextRand() % 8), randDelay());
        end
        endTest("random sequence");

        $display("%0d tests, %0d fetches, %0d checks, %0d errors",
                 testCount, fetchCount, checks, totalErrors());
        if (totalErrors() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
src/icacheGeomPkg.sv
src/icacheCtrlPkg.sv
src/wayInfoIf.sv
src/ctrlStore.sv
src/dataStore.sv
src/replacePolicy.sv
src/icacheControl.sv
src/icacheTop.sv
verification/icache_assertions.sv
verification/icacheTb.sv
